/* hdl/rasterint_gen.sv */
`timescale 1ns/1ps

module rasterint_gen (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   line_tick,
   input  zxuno_pkg::raster_cfg_t cfg,
   output logic                   int_n,
   output logic                   int_in_progress
);

   logic [8:0]                       line_q;
   logic [8:0]                       line_next;
   logic [zxuno_pkg::PULSE_CNT_W-1:0] pulse_q;
   logic                             raster_src_q;
   logic                             pulse_active;
   logic                             hit_raster;
   logic                             hit_vretrace;
   logic                             start_pulse;

   // --------------------------------------------------
   // Line counter
   // --------------------------------------------------
   assign line_next = (line_q == zxuno_pkg::LINES_PER_FRAME - 9'd1) ? 9'd0 : line_q + 9'd1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         line_q <= 9'd0;
      end else if (line_tick) begin
         line_q <= line_next;
      end
   end

   // --------------------------------------------------
   // Interrupt sources, checked against the new line
   // --------------------------------------------------
   assign hit_raster   = cfg.enable && (line_next == cfg.line);
   assign hit_vretrace = (line_next == 9'd0) && !cfg.vretrace_disable;
   assign pulse_active = (pulse_q != '0);

   // No retrigger while a pulse is running
   assign start_pulse = line_tick && !pulse_active && (hit_raster || hit_vretrace);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pulse_q      <= '0;
         raster_src_q <= 1'b0;
      end else if (start_pulse) begin
         pulse_q      <= zxuno_pkg::PULSE_CNT_W'(zxuno_pkg::INT_PULSE_CYCLES);
         raster_src_q <= hit_raster;
      end else if (pulse_active) begin
         pulse_q <= pulse_q - 1'b1;
      end
   end

   // Low for the whole down-count
   assign int_n = !pulse_active;

   // Raster match wins when both sources hit the same line
   assign int_in_progress = raster_src_q && pulse_active;

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   a_pulse_len : assert property (
      @(posedge clk) disable iff (!arst_n)
      $fell(int_n) |-> ##(zxuno_pkg::INT_PULSE_CYCLES) int_n
   ) else $error("int_n pulse longer than INT_PULSE_CYCLES");

   a_line_range : assert property (
      @(posedge clk) disable iff (!arst_n)
      line_q < zxuno_pkg::LINES_PER_FRAME
   ) else $error("line counter out of range");

endmodule

/* hdl/zxuno_io_top.sv */
`timescale 1ns/1ps

module zxuno_io_top (
   input  logic                    clk,
   input  logic                    arst_n,
   input  zxuno_pkg::cpu_bus_t     bus,
   input  logic                    line_tick,
   output logic [7:0]              dout,
   output logic                    int_n,
   output zxuno_pkg::dev_options_t dev_options
);

   zxuno_pkg::reg_access_t acc;
   zxuno_pkg::raster_cfg_t raster_cfg;
   logic                   addr_rd;
   logic                   int_in_progress;

   // CPU bus to register strobes
   zxuno_port_decoder u_decoder (
      .clk     (clk),
      .arst_n  (arst_n),
      .bus     (bus),
      .acc     (acc),
      .addr_rd (addr_rd)
   );

   // Extended register bank and read mux
   zxuno_regbank u_regbank (
      .clk             (clk),
      .arst_n          (arst_n),
      .acc             (acc),
      .addr_rd         (addr_rd),
      .int_in_progress (int_in_progress),
      .dout            (dout),
      .dev_options     (dev_options),
      .raster_cfg      (raster_cfg)
   );

   // Line counter and CPU interrupt
   rasterint_gen u_rasterint (
      .clk             (clk),
      .arst_n          (arst_n),
      .line_tick       (line_tick),
      .cfg             (raster_cfg),
      .int_n           (int_n),
      .int_in_progress (int_in_progress)
   );

endmodule

/* hdl/zxuno_pkg.sv */
package zxuno_pkg;

   // --------------------------------------------------
   // CPU I/O ports and extended register addresses
   // --------------------------------------------------
   localparam logic [15:0] ZXUNO_ADDR_PORT = 16'hFC3B;
   localparam logic [15:0] ZXUNO_DATA_PORT = 16'hFD3B;

   localparam logic [7:0] REG_SCRATCH    = 8'hFE;
   localparam logic [7:0] REG_DEVOPTIONS = 8'h0E;
   localparam logic [7:0] REG_RASTERLINE = 8'h0C;
   localparam logic [7:0] REG_RASTERCTRL = 8'h0D;

   // Value seen on the data bus when nobody drives it
   localparam logic [7:0] BUS_IDLE_DATA = 8'hFF;

   // --------------------------------------------------
   // Raster timing
   // --------------------------------------------------
   localparam logic [8:0] LINES_PER_FRAME  = 9'd312;
   localparam int         INT_PULSE_CYCLES = 32;
   // Wide enough to hold INT_PULSE_CYCLES itself
   localparam int         PULSE_CNT_W      = $clog2(INT_PULSE_CYCLES + 1);

   // --------------------------------------------------
   // Bus and register types
   // --------------------------------------------------
   typedef struct packed {
      logic [15:0] addr;
      logic        iorq_n;
      logic        rd_n;
      logic        wr_n;
      logic [7:0]  data;    // CPU write data
   } cpu_bus_t;

   typedef struct packed {
      logic [7:0] addr;     // current extended register address
      logic       regrd;
      logic       regwr;
      logic [7:0] data;
   } reg_access_t;

   typedef struct packed {
      logic disable_ay;
      logic disable_turboay;
      logic disable_7ffd;
      logic disable_1ffd;
      logic disable_romsel7f;
      logic disable_romsel1f;
      logic enable_timexmmu;
      logic disable_spisd;
   } dev_options_t;

   typedef struct packed {
      logic       in_progress;   // read only
      logic [3:0] reserved;
      logic       vretrace_disable;
      logic       enable;
      logic       line_msb;
   } raster_ctrl_t;

   // One data byte, seen according to the register it targets
   typedef union packed {
      logic [7:0]   raw;
      dev_options_t dev;
      raster_ctrl_t rctl;
   } reg_word_u;

   typedef struct packed {
      logic [8:0] line;
      logic       enable;
      logic       vretrace_disable;
   } raster_cfg_t;

endpackage

/* hdl/zxuno_port_decoder.sv */
`timescale 1ns/1ps

module zxuno_port_decoder (
   input  logic                   clk,
   input  logic                   arst_n,
   input  zxuno_pkg::cpu_bus_t    bus,
   output zxuno_pkg::reg_access_t acc,
   output logic                   addr_rd
);

   logic       io_rd;
   logic       io_wr;
   logic       addr_port_sel;
   logic       data_port_sel;
   logic [7:0] regaddr_q;

   // --------------------------------------------------
   // Z80 I/O cycle qualification
   // --------------------------------------------------
   assign io_rd = !bus.iorq_n && !bus.rd_n;
   assign io_wr = !bus.iorq_n && !bus.wr_n;

   // Full 16-bit compare, no partial decoding
   assign addr_port_sel = (bus.addr == zxuno_pkg::ZXUNO_ADDR_PORT);
   assign data_port_sel = (bus.addr == zxuno_pkg::ZXUNO_DATA_PORT);

   // Register address latch, written through FC3B
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         regaddr_q <= 8'h00;
      end else if (addr_port_sel && io_wr) begin
         regaddr_q <= bus.data;
      end
   end

   // --------------------------------------------------
   // Strobes towards the register bank
   // --------------------------------------------------
   always_comb begin
      acc.addr  = regaddr_q;
      acc.regrd = data_port_sel && io_rd;
      acc.regwr = data_port_sel && io_wr;
      acc.data  = bus.data;
   end

   // FC3B read returns the latched address
   assign addr_rd = addr_port_sel && io_rd;

   // A single bus cycle cannot both read and write the data port
   a_rd_wr_excl : assert property (
      @(posedge clk) disable iff (!arst_n)
      !(acc.regrd && acc.regwr)
   ) else $error("regrd and regwr active together");

endmodule

/* hdl/zxuno_regbank.sv */
`timescale 1ns/1ps

module zxuno_regbank (
   input  logic                    clk,
   input  logic                    arst_n,
   input  zxuno_pkg::reg_access_t  acc,
   input  logic                    addr_rd,
   input  logic                    int_in_progress,
   output logic [7:0]              dout,
   output zxuno_pkg::dev_options_t dev_options,
   output zxuno_pkg::raster_cfg_t  raster_cfg
);

   zxuno_pkg::reg_word_u    wr_word;
   zxuno_pkg::dev_options_t devopt_q;
   zxuno_pkg::raster_cfg_t  rcfg_q;
   zxuno_pkg::raster_ctrl_t ctrl_rd;
   logic [7:0]              scratch_q;

   // Active-low output enables, one per read source
   logic oe_n_zxunoaddr;
   logic oe_n_scratch;
   logic oe_n_devoptions;
   logic oe_n_rasterline;
   logic oe_n_rasterctrl;

   assign wr_word = acc.data;

   // --------------------------------------------------
   // Register writes through FD3B
   // --------------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         scratch_q <= 8'h00;
         devopt_q  <= '0;
         rcfg_q    <= '0;
      end else if (acc.regwr) begin
         case (acc.addr)
            zxuno_pkg::REG_SCRATCH: begin
               scratch_q <= wr_word.raw;
            end
            zxuno_pkg::REG_DEVOPTIONS: begin
               devopt_q <= wr_word.dev;
            end
            zxuno_pkg::REG_RASTERLINE: begin
               rcfg_q.line[7:0] <= wr_word.raw;
            end
            zxuno_pkg::REG_RASTERCTRL: begin
               // in_progress is read only, the write ignores it
               rcfg_q.line[8]          <= wr_word.rctl.line_msb;
               rcfg_q.enable           <= wr_word.rctl.enable;
               rcfg_q.vretrace_disable <= wr_word.rctl.vretrace_disable;
            end
            default: begin
            end
         endcase
      end
   end

   assign dev_options = devopt_q;
   assign raster_cfg  = rcfg_q;

   // Control register as the CPU sees it
   always_comb begin
      ctrl_rd                  = '0;
      ctrl_rd.in_progress      = int_in_progress;
      ctrl_rd.vretrace_disable = rcfg_q.vretrace_disable;
      ctrl_rd.enable           = rcfg_q.enable;
      ctrl_rd.line_msb         = rcfg_q.line[8];
   end

   // --------------------------------------------------
   // Read data mux
   // --------------------------------------------------
   assign oe_n_zxunoaddr  = !addr_rd;
   assign oe_n_scratch    = !(acc.regrd && acc.addr == zxuno_pkg::REG_SCRATCH);
   assign oe_n_devoptions = !(acc.regrd && acc.addr == zxuno_pkg::REG_DEVOPTIONS);
   assign oe_n_rasterline = !(acc.regrd && acc.addr == zxuno_pkg::REG_RASTERLINE);
   assign oe_n_rasterctrl = !(acc.regrd && acc.addr == zxuno_pkg::REG_RASTERCTRL);

   // First enabled source wins, idle bus otherwise
   always_comb begin
      case (1'b0)
         oe_n_zxunoaddr:  dout = acc.addr;
         oe_n_scratch:    dout = scratch_q;
         oe_n_devoptions: dout = devopt_q;
         oe_n_rasterline: dout = rcfg_q.line[7:0];
         oe_n_rasterctrl: dout = ctrl_rd;
         default:         dout = zxuno_pkg::BUS_IDLE_DATA;
      endcase
   end

   // Port decode upstream keeps the sources mutually exclusive
   a_oe_onehot : assert property (
      @(posedge clk) disable iff (!arst_n)
      $onehot0({!oe_n_zxunoaddr, !oe_n_scratch, !oe_n_devoptions,
                !oe_n_rasterline, !oe_n_rasterctrl})
   ) else $error("more than one read source enabled");

endmodule

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f tb.f --top-module tb_zxuno_io -o tb_zxuno_io_sim

# The log decides the verdict, so the pipe status is not used
./obj_dir/tb_zxuno_io_sim 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
   echo "Simulation reported a failure"
   exit 1
fi

if ! grep -q "Test passed" sim.log; then
   echo "Simulation ended without a verdict"
   exit 1
fi

echo "Simulation passed"

/* tb.f */
+incdir+tests
hdl/zxuno_pkg.sv
hdl/zxuno_port_decoder.sv
hdl/zxuno_regbank.sv
hdl/rasterint_gen.sv
hdl/zxuno_io_top.sv
tests/tb_zxuno_io.sv

/* tests/tb_bus_tasks.svh */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// --------------------------------------------------
// Z80 style I/O cycles, started on a falling edge
// --------------------------------------------------

// Strobe held for two clocks
task automatic io_write(input logic [15:0] port, input logic [7:0] data);
   bus.addr   = port;
   bus.data   = data;
   bus.iorq_n = 1'b0;
   bus.wr_n   = 1'b0;
   repeat (2) @(negedge clk);
   bus.iorq_n = 1'b1;
   bus.wr_n   = 1'b1;
endtask

task automatic io_read(input logic [15:0] port, input logic [7:0] expected);
   bus.addr   = port;
   bus.iorq_n = 1'b0;
   bus.rd_n   = 1'b0;
   // Quarter period into the low phase, well clear of both edges
   #2;
   assert (dout === expected) else begin
      abort_run($sformatf("error at %0t: dout expected %h got %h (port %h)",
                          $time, expected, dout, port));
   end
   @(negedge clk);
   bus.iorq_n = 1'b1;
   bus.rd_n   = 1'b1;
endtask

// One-clock line strobes, each followed by idle clocks
task automatic send_ticks(input int count, input int idle);
   for (int i = 0; i < count; i++) begin
      line_tick = 1'b1;
      @(negedge clk);
      line_tick = 1'b0;
      repeat (idle) @(negedge clk);
   end
endtask

task automatic check_dev_options(input logic [7:0] expected);
   assert (dev_options === expected) else begin
      abort_run($sformatf("error at %0t: dev_options expected %h got %h",
                          $time, expected, dev_options));
   end
endtask

// Fills the operation queues and sizes the timeout
task automatic load_stim();
   int    fd;
   int    n;
   int    total_ticks;
   byte   op;
   int    a;
   int    b;
   string line;
   total_ticks = 0;
   fd = $fopen("tests/zxuno_stim.txt", "r");
   if (fd == 0) begin
      abort_run("could not open the stimulus file tests/zxuno_stim.txt");
   end else begin
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 1 && line[0] != "#") begin
            a = 0;
            b = 0;
            n = $sscanf(line, "%c", op);
            if (op == "T") begin
               n = $sscanf(line, "%c %d %d", op, a, b);
               total_ticks += a;
            end else begin
               n = $sscanf(line, "%c %h %h", op, a, b);
            end
            op_q.push_back(op);
            a_q.push_back(a);
            b_q.push_back(b);
         end
      end
      $fclose(fd);
      cycle_limit = op_q.size() * 8 +
                    total_ticks * (zxuno_pkg::INT_PULSE_CYCLES + 4) + 200;
   end
endtask

`endif

/* tests/tb_zxuno_io.sv */
`timescale 1ns/1ps

module tb_zxuno_io;

   logic                    clk;
   logic                    arst_n;
   zxuno_pkg::cpu_bus_t     bus;
   logic                    line_tick;
   logic [7:0]              dout;
   logic                    int_n;
   zxuno_pkg::dev_options_t dev_options;

   // Operation list from the stimulus file
   byte op_q[$];
   int  a_q[$];
   int  b_q[$];

   int          cycle_cnt = 0;
   int          cycle_limit = 0;
   int unsigned gap;

   // Reference model state
   logic [7:0] m_regaddr;
   logic [8:0] m_cfg_line;
   logic       m_en;
   logic       m_vd;
   logic [8:0] m_line;
   logic [8:0] m_next;
   int         m_pulse;
   logic       m_start;

   zxuno_io_top UUT (
      .clk         (clk),
      .arst_n      (arst_n),
      .bus         (bus),
      .line_tick   (line_tick),
      .dout        (dout),
      .int_n       (int_n),
      .dev_options (dev_options)
   );

   // 8 ns period
   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "run stopped at first error");
   endtask

   `include "tb_bus_tasks.svh"

   // --------------------------------------------------
   // Reference model of line counter and int_n window
   // --------------------------------------------------
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         m_regaddr  = 8'h00;
         m_cfg_line = 9'd0;
         m_en       = 1'b0;
         m_vd       = 1'b0;
         m_line     = 9'd0;
         m_pulse    = 0;
      end else begin
         // Tick uses the settings from before any write on this edge
         m_next  = (m_line == 9'd311) ? 9'd0 : m_line + 9'd1;
         m_start = line_tick && (m_pulse == 0) &&
                   ((m_en && m_next == m_cfg_line) || (m_next == 9'd0 && !m_vd));
         if (m_start) begin
            m_pulse = zxuno_pkg::INT_PULSE_CYCLES;
         end else if (m_pulse != 0) begin
            m_pulse = m_pulse - 1;
         end
         if (line_tick) begin
            m_line = m_next;
         end
         if (!bus.iorq_n && !bus.wr_n) begin
            if (bus.addr == 16'hFC3B) begin
               m_regaddr = bus.data;
            end else if (bus.addr == 16'hFD3B && m_regaddr == 8'h0C) begin
               m_cfg_line[7:0] = bus.data;
            end else if (bus.addr == 16'hFD3B && m_regaddr == 8'h0D) begin
               m_cfg_line[8] = bus.data[0];
               m_en          = bus.data[1];
               m_vd          = bus.data[2];
            end
         end
      end
   end

   // int_n settles after the rising edge, so compare mid-cycle
   always @(negedge clk) begin
      if (arst_n) begin
         assert (int_n === (m_pulse == 0)) else begin
            abort_run($sformatf("error at %0t: int_n expected %b got %b",
                                $time, (m_pulse == 0), int_n));
         end
      end
   end

   // Run length guard
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         abort_run($sformatf("timeout: run did not finish within %0d cycles",
                             cycle_limit));
      end
   end

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial begin
      bus.addr   = 16'h0000;
      bus.iorq_n = 1'b1;
      bus.rd_n   = 1'b1;
      bus.wr_n   = 1'b1;
      bus.data   = 8'h00;
      line_tick  = 1'b0;
      arst_n     = 1'b0;
      void'($urandom(23957));
      load_stim();

      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      for (int i = 0; i < op_q.size(); i++) begin
         gap = $urandom_range(3, 0);
         repeat (gap) @(negedge clk);
         case (op_q[i])
            "W": io_write(16'(a_q[i]), 8'(b_q[i]));
            "R": io_read(16'(a_q[i]), 8'(b_q[i]));
            "T": send_ticks(a_q[i], b_q[i]);
            "D": check_dev_options(8'(a_q[i]));
            default: abort_run("unknown operation in stimulus list");
         endcase
      end

      repeat (2) @(negedge clk);
      $display("Test passed");
      $finish;
   end

endmodule

/* tests/zxuno_stim.txt */
# W port data : I/O write | R port expected : I/O read, dout checked (hex)
# T count idle : line ticks, idle clocks after each (decimal) | D expected : dev_options
R FC3B 00
W FC3B FE
R FD3B 00
W FC3B 0E
R FD3B 00
D 00
W FC3B 0C
R FD3B 00
W FC3B 0D
R FD3B 00
R FC3B 0D
R 00FE FF
R FD3C FF
W FC3B 5A
R FC3B 5A
R FD3B FF
W FD3B 77
R FD3B FF
W FC3B FE
W FD3B A5
R FD3B A5
W FC3B 0E
W FD3B 3C
R FD3B 3C
D 3C
W FD3B C1
D C1
R FD3B C1
W FC3B 0C
W FD3B 0A
W FC3B 0D
W FD3B 06
R FD3B 06
T 10 0
R FD3B 86
T 1 34
R FD3B 06
W FC3B 0C
W FD3B 2C
W FC3B 0D
W FD3B 87
R FD3B 07
T 289 0
R FD3B 87
T 1 34
R FD3B 07
T 11 0
R FD3B 07
W FD3B 02
R FD3B 02
T 312 0
R FD3B 02
T 1 34
W FD3B 04
T 100 0
R FD3B 04
W FD3B 00
T 211 0
R FD3B 00
T 1 34
R FC3B 0D
D C1
